/* verilog/branch_pred_pkg.sv */
// instruction fields assume the 32-bit encoding, with compressed instructions presented already expanded
package branch_pred_pkg;

    // plain vector types shared by the predictors and the testbench
    typedef logic [31:0] word_t;    // pc, target or data word
    typedef logic [31:0] instr_t;   // raw fetched instruction
    typedef logic [4:0]  reg_idx_t; // x0..x31

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_JAL  = 7'b1101111; // jal, direct jump
    localparam logic [6:0] OPC_JALR = 7'b1100111; // jalr, register indirect

    // link registers as the calling convention defines them
    // rd of a call or rs1 of a return is one of these two
    localparam reg_idx_t REG_RA = 5'd1;  // x1, standard return address
    localparam reg_idx_t REG_T0 = 5'd5;  // x5, alternate link (millicode)

    // field positions inside a 32-bit instruction
    //   rd  = instr[11:7]
    //   rs1 = instr[19:15]
    // both are decoded locally where needed

endpackage

/* verilog/btb.sv */
// direct-mapped, NFRAMES a power of two >= 2, PRED_BITS 1 or 2, pc bit 0 ignored, no tag or target reset
module btb #(
    parameter int NFRAMES   = 16,  // number of entries
    parameter int PRED_BITS = 2    // direction counter width
) (
    input  logic                   CLK,
    input  logic                   rst_n,
    // lookup side, answered in the same cycle
    input  branch_pred_pkg::word_t current_pc,
    input  logic                   is_rv32c,
    // training from execute
    input  logic                   update_predictor, // one-cycle strobe
    input  branch_pred_pkg::word_t pc_to_update,
    input  logic                   branch_result,    // 1 = resolved taken
    input  branch_pred_pkg::word_t update_addr,      // resolved target
    // prediction
    output logic                   btb_taken,
    output branch_pred_pkg::word_t btb_target
);
    import branch_pred_pkg::*;

    localparam int IDX_W = $clog2(NFRAMES);
    localparam int TAG_W = 32 - IDX_W - 1; // bit 0 never used

    typedef logic [IDX_W-1:0]     idx_t;
    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [PRED_BITS-1:0] cnt_t;

    localparam cnt_t CNT_MAX  = {PRED_BITS{1'b1}};     // strongly taken
    localparam cnt_t CNT_WEAK = cnt_t'(1) << (PRED_BITS - 1); // weakly taken, top bit only

    // storage
    logic  valid      [NFRAMES]; // control, cleared on reset
    cnt_t  cnt        [NFRAMES]; // direction counters
    tag_t  tag_mem    [NFRAMES]; // payload, written on allocation
    word_t target_mem [NFRAMES]; // payload, written on taken updates

    // lookup decode
    idx_t  rd_idx;
    tag_t  rd_tag;
    logic  rd_hit;
    word_t fall_through;

    // update decode
    idx_t  upd_idx;
    tag_t  upd_tag;
    logic  upd_hit;
    logic  upd_alloc;  // miss that was taken, claims the entry
    cnt_t  cnt_next;   // saturated counter for a hit

    assign rd_idx = current_pc[IDX_W:1];      // index starts at bit 1
    assign rd_tag = current_pc[31:IDX_W+1];   // everything above index
    assign rd_hit = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);

    // next sequential pc, half size for compressed
    assign fall_through = current_pc + (is_rv32c ? word_t'(2) : word_t'(4));

    // taken only on a hit with the counter top bit set
    assign btb_taken  = rd_hit && cnt[rd_idx][PRED_BITS-1];
    assign btb_target = btb_taken ? target_mem[rd_idx] : fall_through;

    assign upd_idx   = pc_to_update[IDX_W:1];
    assign upd_tag   = pc_to_update[31:IDX_W+1];
    assign upd_hit   = valid[upd_idx] && (tag_mem[upd_idx] == upd_tag);
    assign upd_alloc = !upd_hit && branch_result; // not-taken misses are dropped

    // saturating step of the hit entry
    always_comb begin
        cnt_next = cnt[upd_idx];
        if (branch_result) begin
            if (cnt[upd_idx] != CNT_MAX)
                cnt_next = cnt[upd_idx] + cnt_t'(1); // count up toward taken
        end else begin
            if (cnt[upd_idx] != '0)
                cnt_next = cnt[upd_idx] - cnt_t'(1); // count down toward not taken
        end
    end

    // valid bits and counters
    always_ff @(posedge CLK, negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NFRAMES; i++) begin
                valid[i] <= 1'b0;
                cnt[i]   <= '0;
            end
        end else if (update_predictor) begin
            if (upd_hit) begin
                cnt[upd_idx] <= cnt_next;
            end else if (upd_alloc) begin
                valid[upd_idx] <= 1'b1;
                cnt[upd_idx]   <= CNT_WEAK; // start weakly taken
            end
        end
    end

    // tags and targets
    always_ff @(posedge CLK) begin
        if (update_predictor) begin
            if (upd_alloc)
                tag_mem[upd_idx] <= upd_tag;       // evicts whatever sat here
            if (branch_result)
                target_mem[upd_idx] <= update_addr; // hit or new entry, latest target wins
        end
    end

endmodule

/* verilog/return_predictor.sv */
// RAS_ENTRIES a power of two >= 2, fetch shows each instruction for one cycle, no speculative repair
module return_predictor #(
    parameter int RAS_ENTRIES = 4  // stack depth
) (
    input  logic                    CLK,
    input  logic                    rst_n,
    input  branch_pred_pkg::word_t  current_pc,
    input  branch_pred_pkg::instr_t instr,     // expanded 32-bit form
    input  logic                    is_jump,   // jal from decode
    input  logic                    is_jalr,   // jalr from decode
    input  logic                    is_rv32c,  // 2-byte instruction
    output logic                    ras_taken,
    output branch_pred_pkg::word_t  ras_target
);
    import branch_pred_pkg::*;

    localparam int PTR_W = $clog2(RAS_ENTRIES);
    localparam int CNT_W = $clog2(RAS_ENTRIES + 1); // holds 0..RAS_ENTRIES

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    localparam cnt_t CNT_FULL = cnt_t'(RAS_ENTRIES);

    // circular stack, no reset on the slots
    word_t stack [RAS_ENTRIES];
    ptr_t  top_ptr;   // slot of the newest entry
    ptr_t  push_ptr;  // slot a push writes
    cnt_t  count;     // live entries, saturates

    // decode
    logic [6:0] opcode;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    logic       rd_link;
    logic       rs1_link;
    logic       jal_op;
    logic       jalr_op;
    logic       is_call;
    logic       is_return;
    logic       empty;
    word_t      fall_through;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];

    // x1 or x5 count as link
    assign rd_link  = (rd == REG_RA) || (rd == REG_T0);
    assign rs1_link = (rs1 == REG_RA) || (rs1 == REG_T0);

    // decode flags qualified by the opcode itself
    assign jal_op  = is_jump && (opcode == OPC_JAL);
    assign jalr_op = is_jalr && (opcode == OPC_JALR);

    assign is_call   = (jal_op || jalr_op) && rd_link;
    assign is_return = jalr_op && rs1_link && !rd_link; // call wins when rd links

    assign empty        = (count == '0);
    assign fall_through = current_pc + (is_rv32c ? word_t'(2) : word_t'(4));

    assign push_ptr = top_ptr + ptr_t'(1); // wraps onto the oldest slot when full

    // old top is visible in the cycle of the pop
    assign ras_taken  = is_return && !empty;
    assign ras_target = ras_taken ? stack[top_ptr] : fall_through;

    // pointer and occupancy
    always_ff @(posedge CLK, negedge rst_n) begin
        if (!rst_n) begin
            top_ptr <= '0;
            count   <= '0;
        end else if (is_call) begin
            top_ptr <= push_ptr;
            if (count != CNT_FULL)
                count <= count + cnt_t'(1); // full stack keeps its count
        end else if (is_return && !empty) begin
            top_ptr <= top_ptr - ptr_t'(1);
            count   <= count - cnt_t'(1);
        end
        // pop on empty stack is ignored
    end

    // return address storage
    always_ff @(posedge CLK) begin
        if (is_call)
            stack[push_ptr] <= fall_through; // link value of the call
    end

endmodule

/* verilog/branch_predictor_wrapper.sv */
// both predictors answer combinationally in the lookup cycle, only the BTB is trained from execute
module branch_predictor_wrapper #(
    parameter int NFRAMES     = 16, // BTB entries, power of two
    parameter int PRED_BITS   = 2,  // 1 or 2 bit counters
    parameter int RAS_ENTRIES = 4   // return stack depth
) (
    input  logic                    CLK,
    input  logic                    rst_n,
    // fetch lookup
    input  branch_pred_pkg::word_t  current_pc,
    input  branch_pred_pkg::instr_t instr,
    input  logic                    is_jump,
    input  logic                    is_jalr,
    input  logic                    is_rv32c,
    // execute training
    input  logic                    update_predictor,
    input  branch_pred_pkg::word_t  pc_to_update,
    input  logic                    branch_result,
    input  branch_pred_pkg::word_t  update_addr,
    // answer to fetch
    output logic                    predict_taken,
    output branch_pred_pkg::word_t  target_addr
);
    import branch_pred_pkg::*;

    // per-predictor answers
    logic  btb_taken;
    word_t btb_target;
    logic  ras_taken;
    word_t ras_target;

    // direction and target for branches and direct jumps
    btb #(
        .NFRAMES   (NFRAMES),
        .PRED_BITS (PRED_BITS)
    ) u_btb (
        .CLK              (CLK),
        .rst_n            (rst_n),
        .current_pc       (current_pc),
        .is_rv32c         (is_rv32c),
        .update_predictor (update_predictor),
        .pc_to_update     (pc_to_update),
        .branch_result    (branch_result),
        .update_addr      (update_addr),
        .btb_taken        (btb_taken),
        .btb_target       (btb_target)
    );

    // returns through jalr, self-trained from the fetched stream
    return_predictor #(
        .RAS_ENTRIES (RAS_ENTRIES)
    ) u_ras (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .current_pc (current_pc),
        .instr      (instr),
        .is_jump    (is_jump),
        .is_jalr    (is_jalr),
        .is_rv32c   (is_rv32c),
        .ras_taken  (ras_taken),
        .ras_target (ras_target)
    );

    // jalr targets come from the stack, everything else from the BTB
    always_comb begin
        if (is_jalr) begin
            predict_taken = ras_taken;
            target_addr   = ras_target;
        end else begin
            predict_taken = btb_taken;
            target_addr   = btb_target;
        end
    end

endmodule

/* testbench/tb_pred_model.svh */
// include inside the testbench module after NFRAMES, PRED_BITS and RAS_ENTRIES are declared
`ifndef TB_PRED_MODEL_SVH
`define TB_PRED_MODEL_SVH

    localparam int IDX_W    = $clog2(NFRAMES);
    localparam int CNT_MAX  = (1 << PRED_BITS) - 1;   // strongest taken
    localparam int CNT_WEAK = 1 << (PRED_BITS - 1);   // first taken value

    // model state of the BTB
    logic  m_valid  [NFRAMES];
    word_t m_tag    [NFRAMES]; // pc above the index bits
    int    m_cnt    [NFRAMES];
    word_t m_target [NFRAMES];

    // model RAS, newest entry at the back
    word_t m_ras [$];

    int check_count;
    int err_count;

    function automatic int btb_index(input word_t pc);
        return int'((pc >> 1) % NFRAMES); // halfword granule
    endfunction

    function automatic word_t btb_tag(input word_t pc);
        return pc >> (IDX_W + 1);
    endfunction

    function automatic logic is_link(input reg_idx_t r);
        return (r == REG_RA) || (r == REG_T0);
    endfunction

    // jal or jalr writing a link register
    function automatic logic is_call(input instr_t ins, input logic jump, input logic jalr);
        logic jal_ok;
        logic jalr_ok;
        jal_ok  = jump && (ins[6:0] == OPC_JAL);
        jalr_ok = jalr && (ins[6:0] == OPC_JALR);
        return (jal_ok || jalr_ok) && is_link(ins[11:7]);
    endfunction

    // jalr through a link register that does not link itself
    function automatic logic is_return(input instr_t ins, input logic jalr);
        return jalr && (ins[6:0] == OPC_JALR) && is_link(ins[19:15]) && !is_link(ins[11:7]);
    endfunction

    function automatic void model_reset();
        for (int i = 0; i < NFRAMES; i++) begin
            m_valid[i] = 1'b0;
            m_cnt[i]   = 0;
        end
        m_ras.delete();
    endfunction

    // answer expected in the lookup cycle, state before the edge
    function automatic void model_predict(input word_t pc, input instr_t ins, input logic jump,
                                          input logic jalr, input logic rv32c,
                                          output logic taken, output word_t target);
        int    idx;
        word_t fall;
        idx    = btb_index(pc);
        fall   = pc + (rv32c ? 32'd2 : 32'd4);
        taken  = 1'b0;
        target = fall;
        if (jalr) begin
            if (is_return(ins, jalr) && m_ras.size() > 0) begin
                taken  = 1'b1;
                target = m_ras[$]; // top of stack
            end
        end else if (m_valid[idx] && m_tag[idx] == btb_tag(pc) && m_cnt[idx] >= CNT_WEAK) begin
            taken  = 1'b1;
            target = m_target[idx];
        end
    endfunction

    // state change at the rising edge
    function automatic void model_clock(input word_t pc, input instr_t ins, input logic jump,
                                        input logic jalr, input logic rv32c, input logic upd,
                                        input word_t upc, input logic res, input word_t uaddr);
        int   idx;
        logic hit;
        if (is_call(ins, jump, jalr)) begin
            m_ras.push_back(pc + (rv32c ? 32'd2 : 32'd4));
            if (m_ras.size() > RAS_ENTRIES)
                m_ras.delete(0); // oldest falls off
        end else if (is_return(ins, jalr) && m_ras.size() > 0) begin
            m_ras.delete(m_ras.size() - 1);
        end
        idx = btb_index(upc);
        hit = m_valid[idx] && (m_tag[idx] == btb_tag(upc));
        if (upd && hit) begin
            if (res) begin
                m_cnt[idx]    = (m_cnt[idx] < CNT_MAX) ? m_cnt[idx] + 1 : CNT_MAX;
                m_target[idx] = uaddr;
            end else begin
                m_cnt[idx] = (m_cnt[idx] > 0) ? m_cnt[idx] - 1 : 0;
            end
        end else if (upd && res) begin
            m_valid[idx]  = 1'b1; // allocate, evicting any other tag
            m_tag[idx]    = btb_tag(upc);
            m_cnt[idx]    = CNT_WEAK;
            m_target[idx] = uaddr;
        end
    endfunction

    task automatic compare_word(input word_t got, input word_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

`endif

/* testbench/tb_branch_predictor.sv */
// DUT runs with default parameters, the localparams below must mirror them for the model
module tb_branch_predictor;
    timeunit 1ns;
    timeprecision 100ps;

    import branch_pred_pkg::*;

    localparam int     CLK_PERIOD   = 8;
    localparam int     HALF_PERIOD  = CLK_PERIOD / 2;
    localparam int     RESET_CYCLES = 5;
    localparam int     NFRAMES      = 16;
    localparam int     PRED_BITS    = 2;
    localparam int     RAS_ENTRIES  = 4;
    localparam int     RANDOM_STEPS = 400;
    localparam int     SETTLE_LIMIT = 10;  // cycles allowed for outputs to come out of reset
    localparam instr_t NOP_INSTR    = 32'h0000_0013; // addi x0, x0, 0

    logic   CLK;
    logic   rst_n;
    word_t  current_pc;
    instr_t instr;
    logic   is_jump;
    logic   is_jalr;
    logic   is_rv32c;
    logic   update_predictor;
    word_t  pc_to_update;
    logic   branch_result;
    word_t  update_addr;
    logic   predict_taken;
    word_t  target_addr;

    logic [31:0] rng_state;
    logic        seen_taken;  // outputs sampled by the last step
    word_t       seen_target;
    int          test_count;
    int          chk_start;
    int          err_start;
    word_t       pc_pool [8]; // several share an index with different tags

    `include "tb_pred_model.svh"

    branch_predictor_wrapper DUT (
        .CLK              (CLK),
        .rst_n            (rst_n),
        .current_pc       (current_pc),
        .instr            (instr),
        .is_jump          (is_jump),
        .is_jalr          (is_jalr),
        .is_rv32c         (is_rv32c),
        .update_predictor (update_predictor),
        .pc_to_update     (pc_to_update),
        .branch_result    (branch_result),
        .update_addr      (update_addr),
        .predict_taken    (predict_taken),
        .target_addr      (target_addr)
    );

    initial begin
        CLK = 1'b0;
        forever #(HALF_PERIOD) CLK = ~CLK;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    function automatic instr_t make_jal(input reg_idx_t rd);
        return {20'h0, rd, OPC_JAL};
    endfunction

    function automatic instr_t make_jalr(input reg_idx_t rd, input reg_idx_t rs1);
        return {12'h0, rs1, 3'b000, rd, OPC_JALR};
    endfunction

    // drive on the falling edge, check just before the rising edge, model steps after it
    task automatic step(input word_t pc, input instr_t ins, input logic jump, input logic jalr,
                        input logic rv32c, input logic upd, input word_t upc, input logic res,
                        input word_t uaddr);
        logic  exp_taken;
        word_t exp_target;
        @(negedge CLK);
        current_pc       = pc;
        instr            = ins;
        is_jump          = jump;
        is_jalr          = jalr;
        is_rv32c         = rv32c;
        update_predictor = upd;
        pc_to_update     = upc;
        branch_result    = res;
        update_addr      = uaddr;
        model_predict(pc, ins, jump, jalr, rv32c, exp_taken, exp_target);
        #(HALF_PERIOD - 1); // just before the edge
        seen_taken  = predict_taken;
        seen_target = target_addr;
        compare_bit(predict_taken, exp_taken, "predict_taken");
        compare_word(target_addr, exp_target, "target_addr");
        @(posedge CLK);
        model_clock(pc, ins, jump, jalr, rv32c, upd, upc, res, uaddr);
    endtask

    task automatic lookup(input word_t pc, input logic rv32c);
        step(pc, NOP_INSTR, 1'b0, 1'b0, rv32c, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic train(input word_t pc, input logic result, input word_t addr);
        step(pc, NOP_INSTR, 1'b0, 1'b0, 1'b0, 1'b1, pc, result, addr);
    endtask

    task automatic call_at(input word_t pc, input logic rv32c);
        step(pc, make_jal(REG_RA), 1'b1, 1'b0, rv32c, 1'b0, '0, 1'b0, '0); // jal ra
    endtask

    task automatic return_at(input word_t pc);
        step(pc, make_jalr(5'd0, REG_RA), 1'b0, 1'b1, 1'b0, 1'b0, '0, 1'b0, '0); // ret
    endtask

    // async reset asserted on a falling edge and held for RESET_CYCLES rising edges
    task automatic hold_reset();
        @(negedge CLK);
        rst_n = 1'b0;
        model_reset();
        for (int i = 0; i < RESET_CYCLES; i++)
            @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
    endtask

    task automatic start_test();
        chk_start = check_count;
        err_start = err_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s: %0d checks, %0d errors", test_count, name,
                 check_count - chk_start, err_count - err_start);
    endtask

    // bounded wait for clean outputs once reset is released
    task automatic wait_reset_release(output logic ok);
        ok = 1'b0;
        for (int n = 0; n < SETTLE_LIMIT && !ok; n++) begin
            @(negedge CLK);
            if (predict_taken === 1'b0 && !$isunknown(target_addr))
                ok = 1'b1;
        end
    endtask

    task automatic test_reset_lookups();
        logic [31:0] r;
        word_t       pc;
        start_test();
        for (int i = 0; i < 20; i++) begin
            r  = next_random();
            pc = {16'h0000, r[15:1], 1'b0};
            lookup(pc, r[16]);
            compare_bit(seen_taken, 1'b0, "taken after reset");
            compare_word(seen_target, pc + (r[16] ? 32'd2 : 32'd4), "fall-through after reset");
        end
        end_test("reset lookups");
    endtask

    task automatic test_btb_training();
        start_test();
        train(32'h0000_5000, 1'b1, 32'h0000_6000); // taken update allocates
        lookup(32'h0000_5000, 1'b0);
        compare_bit(seen_taken, 1'b1, "taken after allocation");
        compare_word(seen_target, 32'h0000_6000, "target after allocation");
        train(32'h0000_5008, 1'b0, 32'h0000_7000); // not-taken miss allocates nothing
        lookup(32'h0000_5008, 1'b0);
        compare_bit(seen_taken, 1'b0, "not-taken miss stays cold");
        // weak taken then one not taken
        train(32'h0000_5010, 1'b1, 32'h0000_8000);
        train(32'h0000_5010, 1'b0, 32'h0000_8000);
        lookup(32'h0000_5010, 1'b0);
        compare_bit(seen_taken, 1'b0, "weak entry flipped");
        // strong taken survives one not taken
        train(32'h0000_5018, 1'b1, 32'h0000_9000);
        train(32'h0000_5018, 1'b1, 32'h0000_9000);
        train(32'h0000_5018, 1'b0, 32'h0000_9000);
        lookup(32'h0000_5018, 1'b0);
        compare_bit(seen_taken, 1'b1, "strong entry holds");
        compare_word(seen_target, 32'h0000_9000, "strong entry target");
        end_test("btb allocation and counters");
    endtask

    task automatic test_tag_conflict();
        start_test();
        train(32'h0000_1004, 1'b1, 32'h0000_a000);
        lookup(32'h0000_1004, 1'b0);
        compare_bit(seen_taken, 1'b1, "first owner hits");
        train(32'h0000_2004, 1'b1, 32'h0000_b000); // same index with a new tag
        lookup(32'h0000_1004, 1'b0);
        compare_bit(seen_taken, 1'b0, "evicted pc misses");
        lookup(32'h0000_2004, 1'b0);
        compare_bit(seen_taken, 1'b1, "new owner hits");
        compare_word(seen_target, 32'h0000_b000, "new owner target");
        end_test("tag conflict");
    endtask

    task automatic test_nested_calls();
        start_test();
        call_at(32'h0000_0100, 1'b0); // pushes 0x104
        call_at(32'h0000_0200, 1'b1); // compressed call pushes 0x202
        call_at(32'h0000_0300, 1'b0);
        return_at(32'h0000_0400);
        compare_word(seen_target, 32'h0000_0304, "innermost return");
        return_at(32'h0000_0400);
        compare_word(seen_target, 32'h0000_0202, "middle return");
        return_at(32'h0000_0400);
        compare_bit(seen_taken, 1'b1, "outer return taken");
        compare_word(seen_target, 32'h0000_0104, "outer return");
        end_test("nested calls");
    endtask

    task automatic test_ras_overflow();
        start_test();
        for (int i = 0; i < RAS_ENTRIES + 2; i++)
            call_at(32'h0000_0600 + word_t'(i * 16), 1'b0);
        for (int k = 0; k < RAS_ENTRIES; k++) begin
            return_at(32'h0000_0700);
            compare_word(seen_target, 32'h0000_0604 + word_t'((RAS_ENTRIES + 1 - k) * 16),
                         "newest entries kept");
        end
        for (int k = 0; k < 2; k++) begin
            return_at(32'h0000_0700);
            compare_bit(seen_taken, 1'b0, "return on empty stack");
            compare_word(seen_target, 32'h0000_0704, "empty stack fall-through");
        end
        end_test("ras overflow and underflow");
    endtask

    // state trained before a second reset must be gone after it
    task automatic test_reset_clears();
        start_test();
        train(32'h0000_6000, 1'b1, 32'h0000_c000);
        call_at(32'h0000_0800, 1'b0); // pushes 0x804
        lookup(32'h0000_6000, 1'b0);
        compare_bit(seen_taken, 1'b1, "entry live before reset");
        hold_reset();
        lookup(32'h0000_6000, 1'b0);
        compare_bit(seen_taken, 1'b0, "entry cleared by reset");
        compare_word(seen_target, 32'h0000_6004, "fall-through after second reset");
        return_at(32'h0000_0900);
        compare_bit(seen_taken, 1'b0, "stack emptied by reset");
        compare_word(seen_target, 32'h0000_0904, "return fall-through after reset");
        end_test("reset clears state");
    endtask

    task automatic test_random_mix();
        logic [31:0] r;
        logic [31:0] r2;
        word_t       pc;
        word_t       upc;
        word_t       addr;
        reg_idx_t    link;
        logic        upd;
        start_test();
        for (int i = 0; i < RANDOM_STEPS; i++) begin
            r    = next_random();
            r2   = next_random();
            pc   = pc_pool[r[2:0]];
            upc  = pc_pool[r[6:4]];
            addr = {r2[31:1], 1'b0};
            link = r[8] ? REG_T0 : REG_RA;
            upd  = r[12] || (r[11:9] >= 3'd5);
            case (r[11:9])
                3'd2:    step(pc, make_jal(link), 1'b1, 1'b0, r[3], upd, upc, r[7], addr);
                3'd3:    step(pc, make_jalr(link, 5'd10), 1'b0, 1'b1, r[3], upd, upc, r[7], addr);
                3'd4:    step(pc, make_jalr(5'd0, link), 1'b0, 1'b1, r[3], upd, upc, r[7], addr);
                3'd5:    step(pc, make_jal(5'd0), 1'b1, 1'b0, r[3], upd, upc, r[7], addr);
                default: step(pc, NOP_INSTR, 1'b0, 1'b0, r[3], upd, upc, r[7], addr);
            endcase
        end
        end_test("random mix");
    endtask

    initial begin
        logic settled;
        rng_state        = 32'h4180b90d;
        check_count      = 0;
        err_count        = 0;
        test_count       = 0;
        rst_n            = 1'b0;
        current_pc       = '0;
        instr            = NOP_INSTR;
        is_jump          = 1'b0;
        is_jalr          = 1'b0;
        is_rv32c         = 1'b0;
        update_predictor = 1'b0;
        pc_to_update     = '0;
        branch_result    = 1'b0;
        update_addr      = '0;
        pc_pool = '{32'h0000_1000, 32'h0000_1004, 32'h0000_100c, 32'h0000_1022,
                    32'h0000_2000, 32'h0000_2004, 32'h0000_3022, 32'h0000_4016};
        hold_reset();
        wait_reset_release(settled);
        if (settled) begin
            test_reset_lookups();
            test_btb_training();
            test_tag_conflict();
            test_nested_calls();
            test_ras_overflow();
            test_reset_clears();
            test_random_mix();
        end else begin
            $display("timeout: DUT outputs never settled after reset release");
        end
        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
        if (settled && err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+testbench
verilog/branch_pred_pkg.sv
verilog/btb.sv
verilog/return_predictor.sv
verilog/branch_predictor_wrapper.sv
testbench/tb_branch_predictor.sv

/* Makefile */
# Verilator build and run of the branch predictor testbench
VERILATOR ?= verilator
TOP       := tb_branch_predictor
FILELIST  := project.f
VFLAGS    := --binary --timing -j 0
BUILD_DIR := obj_dir
LOG       := sim.log

# every source named in the file list, plus the included model
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard testbench/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source, the header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides, not the exit status of the binary
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
